// ==== all.f ====
logic/bus_pkg.sv
logic/sramx_to_axi.sv
logic/axi_mem_slave.sv
logic/mem_bridge_top.sv
bench/mem_bridge_tb.sv

// ==== Makefile ====
TOP = mem_bridge_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing -f all.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log
	cat sim.log
	@if grep -q "ERRORS FOUND" sim.log; then echo "simulation failed"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

// ==== bench/mem_bridge_tb.sv ====
`timescale 1ns/1ps

module mem_bridge_tb
    import bus_pkg::*;
();
    localparam int total_requests = 64 + 48 + 16 + 300;
    localparam int cycle_limit    = 2 * total_requests * 3;

    logic              clk;
    logic              reset;
    logic              req;
    logic              wr;
    sramx_size_t       size;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] wdata;
    logic              addr_ok;
    logic              data_ok;
    logic [data_w-1:0] rdata;

    integer seed = 32'h13756d1f;

    // reference memory and the words that hold fully written data.
    logic [data_w-1:0] model [mem_words];
    logic              known [mem_words];
    logic [data_w-1:0] exp_reads [$];

    int   errors;
    int   checks;
    int   tests;
    int   cycle_count = 0;
    int   accepted;
    int   completed;
    logic prev_accept;
    logic prev_read;

    mem_bridge_top i_dut (
        .clk     (clk),
        .reset   (reset),
        .req     (req),
        .wr      (wr),
        .size    (size),
        .addr    (addr),
        .wdata   (wdata),
        .addr_ok (addr_ok),
        .data_ok (data_ok),
        .rdata   (rdata)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: run stopped after %0d cycles with requests unfinished",
                     cycle_count);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    function automatic int rand_below(input int n);
        rand_below = int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic [addr_w-1:0] word_addr(input int idx, input int off);
        word_addr = addr_w'(idx * strb_w + off);
    endfunction

    // byte lanes covered by an aligned access; a misaligned one covers none.
    function automatic logic [strb_w-1:0] lane_mask(input sramx_size_t sz, input int off);
        int nbytes;
        lane_mask = '0;
        nbytes    = (sz == size_word) ? 4 : (sz == size_half) ? 2 : 1;
        if (off % nbytes == 0) begin
            for (int lane = 0; lane < strb_w; lane++) begin
                lane_mask[lane] = (lane >= off) && (lane < off + nbytes);
            end
        end
    endfunction

    task automatic check_word(input logic [data_w-1:0] got, input logic [data_w-1:0] exp,
                              input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // check the port at the falling edge and then update the model.
    task automatic sample_cycle(output logic took);
        logic [mem_idx_w-1:0] idx;
        logic [strb_w-1:0]    mask;
        @(negedge clk);
        took = req && addr_ok;
        idx  = addr[off_w +: mem_idx_w];
        check_bit(addr_ok, !prev_accept, "addr_ok");
        check_bit(data_ok, (took && wr) || prev_read, "data_ok");
        if (data_ok)
            completed++;
        if (prev_read)
            check_word(rdata, exp_reads.pop_front(), "rdata");
        if (took) begin
            accepted++;
            if (wr) begin
                mask = lane_mask(size, int'(addr[off_w-1:0]));
                for (int lane = 0; lane < strb_w; lane++) begin
                    if (mask[lane])
                        model[idx][8*lane +: 8] = wdata[8*lane +: 8];
                end
                if (mask == '1)
                    known[idx] = 1'b1;
            end else begin
                exp_reads.push_back(model[idx]);
            end
        end
        prev_accept = took;
        prev_read   = took && !wr;
        @(posedge clk);
        #2;
    endtask

    task automatic drive_idle();
        req   = 1'b0;
        wr    = 1'(rand_below(2));
        addr  = addr_w'(rand_below(mem_words * strb_w));
        wdata = $random(seed);
    endtask

    task automatic drain(input int n);
        logic took;
        repeat (n) begin
            drive_idle();
            sample_cycle(took);
        end
    endtask

    // wait a random idle gap and hold the request until it is taken.
    task automatic do_request(input logic is_wr, input sramx_size_t sz,
                              input logic [addr_w-1:0] a, input logic [data_w-1:0] d,
                              input int max_gap);
        logic took;
        drain(rand_below(max_gap + 1));
        req   = 1'b1;
        wr    = is_wr;
        size  = sz;
        addr  = a;
        wdata = d;
        took  = 1'b0;
        while (!took)
            sample_cycle(took);
    endtask

    task automatic finish_test(input string name, input int errors_before, input int expected);
        drain(3);
        tests++;
        if (accepted != expected || completed != expected) begin
            errors++;
            $display("%s: %0d requests issued, %0d accepted, %0d completed",
                     name, expected, accepted, completed);
        end
        $display("test %-12s %s", name, (errors == errors_before) ? "passed" : "failed");
        accepted  = 0;
        completed = 0;
    endtask

    initial begin
        int          errs;
        int          idx;
        int          off;
        logic        is_wr;
        logic        took;
        sramx_size_t sz;

        reset       = 1'b1;
        req         = 1'b0;
        wr          = 1'b0;
        size        = size_word;
        addr        = '0;
        wdata       = '0;
        errors      = 0;
        checks      = 0;
        tests       = 0;
        accepted    = 0;
        completed   = 0;
        prev_accept = 1'b0;
        prev_read   = 1'b0;
        for (int i = 0; i < mem_words; i++) begin
            model[i] = '0;
            known[i] = 1'b0;
        end

        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;

        errs = errors;
        sample_cycle(took);
        finish_test("reset_state", errs, 0);

        errs = errors;
        for (int i = 0; i < 32; i++)
            do_request(1'b1, size_word, word_addr(i, 0), $random(seed), 0);
        for (int i = 0; i < 32; i++)
            do_request(1'b0, size_word, word_addr(i, 0), '0, 0);
        finish_test("word_rw", errs, 64);

        errs = errors;
        for (int i = 0; i < 24; i++) begin
            idx = rand_below(32);
            if (rand_below(2) == 1) begin
                sz  = size_byte;
                off = rand_below(4);
            end else begin
                sz  = size_half;
                off = 2 * rand_below(2);
            end
            do_request(1'b1, sz, word_addr(idx, off), $random(seed), 0);
            do_request(1'b0, size_word, word_addr(idx, 0), '0, 0);
        end
        finish_test("partial_wr", errs, 48);

        // requests back to back that alternate between read and write.
        errs = errors;
        for (int i = 0; i < 16; i++)
            do_request(1'(i % 2), size_word, word_addr(i, 0), $random(seed), 0);
        finish_test("timing", errs, 16);

        errs = errors;
        for (int i = 0; i < 300; i++) begin
            is_wr = 1'(rand_below(2));
            case (rand_below(3))
                0: begin
                    sz  = size_byte;
                    off = rand_below(4);
                end
                1: begin
                    sz  = size_half;
                    off = 2 * rand_below(2);
                end
                default: begin
                    sz  = size_word;
                    off = 0;
                end
            endcase
            idx = rand_below(mem_words);
            // reads stay on words whose every byte has been written.
            if (!is_wr && !known[idx])
                idx = idx % 32;
            do_request(is_wr, sz, word_addr(idx, off), $random(seed), 2);
        end
        finish_test("random_mix", errs, 300);

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

// ==== logic/mem_bridge_top.sv ====
`timescale 1ns/1ps

module mem_bridge_top
    import bus_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              req,
    input  logic              wr,
    input  sramx_size_t       size,
    input  logic [addr_w-1:0] addr,
    input  logic [data_w-1:0] wdata,
    output logic              addr_ok,
    output logic              data_ok,
    output logic [data_w-1:0] rdata
);
    logic              ar_valid;
    logic              ar_ready;
    logic [addr_w-1:0] ar_addr;
    axi_size_t         ar_size;

    logic              r_valid;
    logic              r_ready;
    logic [data_w-1:0] r_data;
    logic              r_last;

    logic              aw_valid;
    logic              aw_ready;
    logic [addr_w-1:0] aw_addr;
    axi_size_t         aw_size;

    logic              w_valid;
    logic              w_ready;
    logic [data_w-1:0] w_data;
    logic [strb_w-1:0] w_strb;
    logic              w_last;

    logic              b_valid;
    logic              b_ready;

    sramx_to_axi i_bridge (
        .clk      (clk),
        .reset    (reset),
        .req      (req),
        .wr       (wr),
        .size     (size),
        .addr     (addr),
        .wdata    (wdata),
        .addr_ok  (addr_ok),
        .data_ok  (data_ok),
        .rdata    (rdata),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .ar_addr  (ar_addr),
        .ar_size  (ar_size),
        .r_valid  (r_valid),
        .r_ready  (r_ready),
        .r_data   (r_data),
        .r_last   (r_last),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .aw_addr  (aw_addr),
        .aw_size  (aw_size),
        .w_valid  (w_valid),
        .w_ready  (w_ready),
        .w_data   (w_data),
        .w_strb   (w_strb),
        .w_last   (w_last),
        .b_valid  (b_valid),
        .b_ready  (b_ready)
    );

    axi_mem_slave i_mem (
        .clk      (clk),
        .reset    (reset),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .ar_addr  (ar_addr),
        .ar_size  (ar_size),
        .r_valid  (r_valid),
        .r_ready  (r_ready),
        .r_data   (r_data),
        .r_last   (r_last),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .aw_addr  (aw_addr),
        .aw_size  (aw_size),
        .w_valid  (w_valid),
        .w_ready  (w_ready),
        .w_data   (w_data),
        .w_strb   (w_strb),
        .w_last   (w_last),
        .b_valid  (b_valid),
        .b_ready  (b_ready)
    );

endmodule

// ==== logic/axi_mem_slave.sv ====
`timescale 1ns/1ps

module axi_mem_slave
    import bus_pkg::*;
(
    input  logic              clk,
    input  logic              reset,

    input  logic              ar_valid,
    output logic              ar_ready,
    input  logic [addr_w-1:0] ar_addr,
    input  axi_size_t         ar_size,

    output logic              r_valid,
    input  logic              r_ready,
    output logic [data_w-1:0] r_data,
    output logic              r_last,

    input  logic              aw_valid,
    output logic              aw_ready,
    input  logic [addr_w-1:0] aw_addr,
    input  axi_size_t         aw_size,

    input  logic              w_valid,
    output logic              w_ready,
    input  logic [data_w-1:0] w_data,
    input  logic [strb_w-1:0] w_strb,
    input  logic              w_last,

    output logic              b_valid,
    input  logic              b_ready
);
    mem_state_t        state;
    logic              have_aw;

    logic [addr_w-1:0] wr_addr;
    axi_size_t         wr_size;
    logic [data_w-1:0] wr_data;
    logic [strb_w-1:0] wr_strb;
    logic [data_w-1:0] rd_data;

    logic [data_w-1:0] mem [mem_words];

    logic                 ar_fire;
    logic                 aw_fire;
    logic                 w_fire;
    logic                 mem_we;
    logic [mem_idx_w-1:0] mem_idx;
    logic [data_w-1:0]    mem_wdata;
    logic [strb_w-1:0]    mem_strb;

    // lanes an access of this size may touch at this offset.
    function automatic logic [strb_w-1:0] size_lanes(input axi_size_t sz,
                                                     input logic [off_w-1:0] off);
        case (sz)
            axi_size_1: size_lanes = strb_w'(1) << off;
            axi_size_2: size_lanes = off[0] ? '0 : strb_w'(3) << off;
            axi_size_4: size_lanes = (off == '0) ? '1 : '0;
            default:    size_lanes = '0;
        endcase
    endfunction

    // a read in idle blocks both write channels.
    assign ar_ready = (state == st_idle);
    assign aw_ready = (state == st_idle && !ar_valid)
                   || (state == st_write_collect && !have_aw);
    assign w_ready  = (state == st_idle && !ar_valid)
                   || (state == st_write_collect && have_aw);

    assign ar_fire = ar_valid & ar_ready;
    assign aw_fire = aw_valid & aw_ready;
    assign w_fire  = w_valid & w_ready & w_last;

    assign r_valid = (state == st_read_resp);
    assign r_data  = rd_data;
    assign r_last  = r_valid;
    assign b_valid = (state == st_write_resp);

    // the write source is either the live channels or the half latched earlier.
    always_comb begin
        mem_we    = 1'b0;
        mem_idx   = aw_addr[off_w +: mem_idx_w];
        mem_wdata = w_data;
        mem_strb  = w_strb & size_lanes(aw_size, aw_addr[off_w-1:0]);
        case (state)
            st_idle: mem_we = aw_fire & w_fire;
            st_write_collect: begin
                if (have_aw) begin
                    mem_we   = w_fire;
                    mem_idx  = wr_addr[off_w +: mem_idx_w];
                    mem_strb = w_strb & size_lanes(wr_size, wr_addr[off_w-1:0]);
                end else begin
                    mem_we    = aw_fire;
                    mem_wdata = wr_data;
                    mem_strb  = wr_strb & size_lanes(aw_size, aw_addr[off_w-1:0]);
                end
            end
            default: mem_we = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (mem_we) begin
            for (int i = 0; i < strb_w; i++) begin
                if (mem_strb[i])
                    mem[mem_idx][8*i +: 8] <= mem_wdata[8*i +: 8];
            end
        end
        if (ar_fire)
            rd_data <= mem[ar_addr[off_w +: mem_idx_w]];
    end

    always_ff @(posedge clk) begin
        if (state == st_idle) begin
            if (aw_fire) begin
                wr_addr <= aw_addr;
                wr_size <= aw_size;
            end
            if (w_fire) begin
                wr_data <= w_data;
                wr_strb <= w_strb;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= st_idle;
            have_aw <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (ar_fire) begin
                        state <= st_read_resp;
                    end else if (aw_fire && w_fire) begin
                        state <= st_write_resp;
                    end else if (aw_fire || w_fire) begin
                        have_aw <= aw_fire;
                        state   <= st_write_collect;
                    end
                end
                st_read_resp: begin
                    if (r_ready)
                        state <= st_idle;
                end
                st_write_collect: begin
                    if (mem_we)
                        state <= st_write_resp;
                end
                st_write_resp: begin
                    if (b_ready)
                        state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

// ==== logic/sramx_to_axi.sv ====
`timescale 1ns/1ps

module sramx_to_axi
    import bus_pkg::*;
(
    input  logic              clk,
    input  logic              reset,

    input  logic              req,
    input  logic              wr,
    input  sramx_size_t       size,
    input  logic [addr_w-1:0] addr,
    input  logic [data_w-1:0] wdata,
    output logic              addr_ok,
    output logic              data_ok,
    output logic [data_w-1:0] rdata,

    output logic              ar_valid,
    input  logic              ar_ready,
    output logic [addr_w-1:0] ar_addr,
    output axi_size_t         ar_size,

    input  logic              r_valid,
    output logic              r_ready,
    input  logic [data_w-1:0] r_data,
    input  logic              r_last,

    output logic              aw_valid,
    input  logic              aw_ready,
    output logic [addr_w-1:0] aw_addr,
    output axi_size_t         aw_size,

    output logic              w_valid,
    input  logic              w_ready,
    output logic [data_w-1:0] w_data,
    output logic [strb_w-1:0] w_strb,
    output logic              w_last,

    input  logic              b_valid,
    output logic              b_ready
);
    logic [chan_w-1:0] pending;
    logic [chan_w-1:0] next_issue;
    logic [chan_w-1:0] issue;
    logic [chan_w-1:0] handshake;
    logic [chan_w-1:0] remain;
    logic              busy;

    sramx_size_t       saved_size;
    logic [addr_w-1:0] saved_addr;
    logic [data_w-1:0] saved_wdata;

    sramx_size_t       body_size;
    logic [addr_w-1:0] body_addr;
    logic [data_w-1:0] body_wdata;
    axi_size_t         body_axi_size;
    logic [strb_w-1:0] body_strb;

    // channels a fresh request would open.
    always_comb begin
        next_issue = '0;
        if (req) begin
            if (wr) begin
                next_issue[ch_aw] = 1'b1;
                next_issue[ch_w]  = 1'b1;
                next_issue[ch_b]  = 1'b1;
            end else begin
                next_issue[ch_ar] = 1'b1;
                next_issue[ch_r]  = 1'b1;
            end
        end
    end

    // while idle the incoming request drives the channels directly.
    assign busy  = |pending;
    assign issue = busy ? pending : next_issue;

    assign handshake[ch_ar] = issue[ch_ar] & ar_ready;
    assign handshake[ch_r]  = issue[ch_r] & r_valid & r_last;
    assign handshake[ch_aw] = issue[ch_aw] & aw_ready;
    assign handshake[ch_w]  = issue[ch_w] & w_ready;
    assign handshake[ch_b]  = issue[ch_b] & b_valid;
    assign remain           = issue & ~handshake;

    always_comb begin
        if (busy) begin
            body_size  = saved_size;
            body_addr  = saved_addr;
            body_wdata = saved_wdata;
        end else begin
            body_size  = size;
            body_addr  = addr;
            body_wdata = wdata;
        end
    end

    always_comb begin
        case (body_size)
            size_half: body_axi_size = axi_size_2;
            size_word: body_axi_size = axi_size_4;
            default:   body_axi_size = axi_size_1;
        endcase
    end

    // misaligned size/offset pairs give no lanes at all.
    always_comb begin
        body_strb = '0;
        case (body_size)
            size_byte: body_strb = strb_w'(1) << body_addr[off_w-1:0];
            size_half: begin
                if (!body_addr[0])
                    body_strb = strb_w'(3) << body_addr[off_w-1:0];
            end
            size_word: begin
                if (body_addr[off_w-1:0] == '0)
                    body_strb = '1;
            end
            default: body_strb = '0;
        endcase
    end

    assign addr_ok = !busy;
    assign data_ok = handshake[ch_r] | handshake[ch_w];
    assign rdata   = r_data;

    assign ar_valid = issue[ch_ar];
    assign ar_addr  = body_addr;
    assign ar_size  = body_axi_size;
    assign r_ready  = issue[ch_r];

    assign aw_valid = issue[ch_aw];
    assign aw_addr  = body_addr;
    assign aw_size  = body_axi_size;

    assign w_valid = issue[ch_w];
    assign w_data  = body_wdata;
    assign w_strb  = body_strb;
    assign w_last  = 1'b1;
    assign b_ready = issue[ch_b];

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= '0;
        end else begin
            pending <= remain;
        end
    end

    always_ff @(posedge clk) begin
        if (!busy) begin
            saved_size  <= size;
            saved_addr  <= addr;
            saved_wdata <= wdata;
        end
    end

endmodule

// ==== logic/bus_pkg.sv ====
package bus_pkg;

    localparam int addr_w    = 32;
    localparam int data_w    = 32;
    localparam int strb_w    = data_w / 8;
    localparam int off_w     = $clog2(strb_w);
    localparam int mem_words = 256;
    localparam int mem_idx_w = $clog2(mem_words);

    // pending-channel mask of the bridge has one bit per AXI channel.
    localparam int chan_w = 5;
    localparam int ch_ar  = 4;
    localparam int ch_r   = 3;
    localparam int ch_aw  = 2;
    localparam int ch_w   = 1;
    localparam int ch_b   = 0;

    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } sramx_size_t;

    // AxSIZE gives the bytes per beat as a power of two.
    typedef enum logic [2:0] {
        axi_size_1 = 3'd0,
        axi_size_2 = 3'd1,
        axi_size_4 = 3'd2
    } axi_size_t;

    typedef enum logic [1:0] {
        st_idle,
        st_read_resp,
        st_write_collect,
        st_write_resp
    } mem_state_t;

endpackage
